/* dv/soc_mem_responder.sv */
`timescale 1ns/100ps

module soc_mem_responder (
	input  logic         clock,
	input  logic         arst_n,
	input  axi_pkg::ar_t io_ar,
	input  logic         io_arvalid,
	output logic         io_arready,
	output axi_pkg::r_t  io_r,
	output logic         io_rvalid,
	input  logic         io_rready,
	input  axi_pkg::aw_t io_aw,
	input  logic         io_awvalid,
	output logic         io_awready,
	input  axi_pkg::w_t  io_w,
	input  logic         io_wvalid,
	output logic         io_wready,
	output axi_pkg::b_t  io_b,
	output logic         io_bvalid,
	input  logic         io_bready
);
	import axi_pkg::*;

	data_t stored [addr_t];  // Words written over the bus

	function automatic data_t word_at(input addr_t a);
		addr_t wa;
		wa = {a[31:2], 2'b00};
		if (stored.exists(wa)) begin
			return stored[wa];
		end
		return wa ^ 32'h5a5a_0000;
	endfunction

	initial begin : read_side
		ar_t req;
		int  lat;
		io_arready = 1'b0;
		io_rvalid  = 1'b0;
		io_r       = '0;
		wait (arst_n === 1'b1);
		forever begin
			@(negedge clock);
			io_arready = 1'b1;
			@(posedge clock);
			while (!io_arvalid) begin
				@(posedge clock);
			end
			req = io_ar;
			@(negedge clock);
			io_arready = 1'b0;
			lat = 1 + int'(req.addr[3:2]) % 3;  // 1 to 3 cycles
			repeat (lat - 1) @(negedge clock);
			for (int beat = 0; beat <= int'(req.len); beat++) begin
				io_r.data = word_at(req.addr + addr_t'(beat * 4));
				io_r.resp = resp_okay;
				io_r.last = (beat == int'(req.len));
				io_rvalid = 1'b1;
				@(posedge clock);
				while (!io_rready) begin
					@(posedge clock);
				end
				@(negedge clock);
				io_rvalid = 1'b0;
			end
		end
	end

	initial begin : write_side
		aw_t   aw_req;
		w_t    w_req;
		data_t word;
		io_awready = 1'b0;
		io_wready  = 1'b0;
		io_bvalid  = 1'b0;
		io_b       = '0;
		wait (arst_n === 1'b1);
		forever begin
			@(negedge clock);
			io_awready = 1'b1;
			io_wready  = 1'b1;
			@(posedge clock);
			while (!(io_awvalid && io_wvalid)) begin
				@(posedge clock);
			end
			aw_req = io_aw;
			w_req  = io_w;
			word   = word_at(aw_req.addr);
			for (int i = 0; i < 4; i++) begin
				if (w_req.strb[i]) begin
					word[8*i +: 8] = w_req.data[8*i +: 8];
				end
			end
			stored[{aw_req.addr[31:2], 2'b00}] = word;
			@(negedge clock);
			io_awready = 1'b0;
			io_wready  = 1'b0;
			io_b.resp  = resp_okay;
			io_bvalid  = 1'b1;
			@(posedge clock);
			while (!io_bready) begin
				@(posedge clock);
			end
			@(negedge clock);
			io_bvalid = 1'b0;
		end
	end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int period_ns    = 20,
	parameter int reset_cycles = 2
) (
	output logic clock,
	output logic arst_n
);

	initial begin
		clock = 1'b0;
		forever #(period_ns / 2) clock = ~clock;
	end

	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;  // Released away from the active edge
	end

endmodule

/* dv/tb_core_bus.sv */
`timescale 1ns/100ps

module tb_core_bus;
	import axi_pkg::*;
	import soc_map_pkg::*;

	localparam int beat_cnt_w      = 4;
	localparam int tick_div        = 2;
	localparam int max_lines       = 32;
	localparam int words_per_line  = 6;
	localparam int cycles_per_line = 200;
	localparam int reset_margin    = 10;

	localparam logic [3:0] op_ifu_read  = 4'h1;
	localparam logic [3:0] op_lsu_read  = 4'h2;
	localparam logic [3:0] op_lsu_write = 4'h3;
	localparam logic [3:0] op_paired    = 4'h4;

	logic  clock;
	logic  arst_n;
	ar_t   ifu_ar;
	logic  ifu_arvalid;
	logic  ifu_arready;
	r_t    ifu_r;
	logic  ifu_rvalid;
	logic  ifu_rready;
	ar_t   lsu_ar;
	logic  lsu_arvalid;
	logic  lsu_arready;
	r_t    lsu_r;
	logic  lsu_rvalid;
	logic  lsu_rready;
	aw_t   lsu_aw;
	logic  lsu_awvalid;
	logic  lsu_awready;
	w_t    lsu_w;
	logic  lsu_wvalid;
	logic  lsu_wready;
	b_t    lsu_b;
	logic  lsu_bvalid;
	logic  lsu_bready;
	ar_t   io_ar;
	logic  io_arvalid;
	logic  io_arready;
	r_t    io_r;
	logic  io_rvalid;
	logic  io_rready;
	aw_t   io_aw;
	logic  io_awvalid;
	logic  io_awready;
	w_t    io_w;
	logic  io_wvalid;
	logic  io_wlast;
	logic  io_wready;
	b_t    io_b;
	logic  io_bvalid;
	logic  io_bready;

	logic [31:0] stim_words [0:max_lines*words_per_line-1];
	int          num_lines;
	int          cycle_limit = 0;
	int          cycle_count;
	int          error_count = 0;
	integer      seed;
	data_t       model_mem [addr_t];  // Expected contents after writes
	bit          have_mtime = 1'b0;
	data_t       last_mtime;
	time         ifu_last_time;
	time         lsu_first_time;

	tb_clock_gen clk0 (
		.clock (clock),
		.arst_n(arst_n)
	);

	core_bus_top #(
		.beat_cnt_w(beat_cnt_w),
		.tick_div  (tick_div)
	) dut0 (
		.clock(clock), .arst_n(arst_n),
		.ifu_ar(ifu_ar), .ifu_arvalid(ifu_arvalid), .ifu_arready(ifu_arready),
		.ifu_r(ifu_r), .ifu_rvalid(ifu_rvalid), .ifu_rready(ifu_rready),
		.lsu_ar(lsu_ar), .lsu_arvalid(lsu_arvalid), .lsu_arready(lsu_arready),
		.lsu_r(lsu_r), .lsu_rvalid(lsu_rvalid), .lsu_rready(lsu_rready),
		.lsu_aw(lsu_aw), .lsu_awvalid(lsu_awvalid), .lsu_awready(lsu_awready),
		.lsu_w(lsu_w), .lsu_wvalid(lsu_wvalid), .lsu_wready(lsu_wready),
		.lsu_b(lsu_b), .lsu_bvalid(lsu_bvalid), .lsu_bready(lsu_bready),
		.io_ar(io_ar), .io_arvalid(io_arvalid), .io_arready(io_arready),
		.io_r(io_r), .io_rvalid(io_rvalid), .io_rready(io_rready),
		.io_aw(io_aw), .io_awvalid(io_awvalid), .io_awready(io_awready),
		.io_w(io_w), .io_wvalid(io_wvalid), .io_wlast(io_wlast), .io_wready(io_wready),
		.io_b(io_b), .io_bvalid(io_bvalid), .io_bready(io_bready)
	);

	soc_mem_responder mem0 (
		.clock(clock), .arst_n(arst_n),
		.io_ar(io_ar), .io_arvalid(io_arvalid), .io_arready(io_arready),
		.io_r(io_r), .io_rvalid(io_rvalid), .io_rready(io_rready),
		.io_aw(io_aw), .io_awvalid(io_awvalid), .io_awready(io_awready),
		.io_w(io_w), .io_wvalid(io_wvalid), .io_wready(io_wready),
		.io_b(io_b), .io_bvalid(io_bvalid), .io_bready(io_bready)
	);

	task automatic stop_on_error(input string msg);
		error_count++;
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_resp(input resp_t got, input resp_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
		end
	endtask

	task automatic check_last(input bit got, input bit exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch at %0t: %s got %0b expected %0b", $time, what, got, exp));
		end
	endtask

	function automatic data_t expected_word(input addr_t a);
		addr_t wa;
		wa = {a[31:2], 2'b00};
		if (model_mem.exists(wa)) begin
			return model_mem[wa];
		end
		return wa ^ 32'h5a5a_0000;
	endfunction

	function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t strb);
		data_t merged;
		merged = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				merged[8*i +: 8] = wdata[8*i +: 8];
			end
		end
		return merged;
	endfunction

	task automatic issue_ifu_read(input addr_t addr, input len_t len, input resp_t exp_resp);
		r_t got;
		int beat;
		@(negedge clock);
		ifu_ar.addr  = addr;
		ifu_ar.len   = len;
		ifu_ar.size  = 3'd2;
		ifu_ar.burst = 2'b01;  // INCR
		ifu_arvalid  = 1'b1;
		@(posedge clock);
		while (!ifu_arready) begin
			@(posedge clock);
		end
		@(negedge clock);
		ifu_arvalid = 1'b0;
		beat = 0;
		while (beat <= int'(len)) begin
			@(posedge clock);
			if (ifu_rvalid && ifu_rready) begin
				got = ifu_r;
				check_data(got.data, expected_word(addr + addr_t'(beat * 4)),
					$sformatf("ifu beat %0d data", beat));
				check_resp(got.resp, exp_resp, $sformatf("ifu beat %0d resp", beat));
				check_last(got.last, beat == int'(len), $sformatf("ifu beat %0d last", beat));
				beat++;
			end
		end
		ifu_last_time = $time;
	endtask

	task automatic issue_lsu_read(input addr_t addr, input resp_t exp_resp);
		r_t    got;
		addr_t offset;
		@(negedge clock);
		lsu_ar.addr  = addr;
		lsu_ar.len   = '0;
		lsu_ar.size  = 3'd2;
		lsu_ar.burst = 2'b01;
		lsu_arvalid  = 1'b1;
		@(posedge clock);
		while (!lsu_arready) begin
			@(posedge clock);
		end
		@(negedge clock);
		lsu_arvalid = 1'b0;
		@(posedge clock);
		while (!(lsu_rvalid && lsu_rready)) begin
			@(posedge clock);
		end
		got            = lsu_r;
		lsu_first_time = $time;
		check_resp(got.resp, exp_resp, "lsu resp");
		check_last(got.last, 1'b1, "lsu last");
		if (addr >= clint_base && addr <= clint_limit) begin
			offset = addr - clint_base;
			if (offset == {24'h0, mtime_lo_off}) begin
				if (have_mtime && !(got.data > last_mtime)) begin
					stop_on_error($sformatf("mismatch at %0t: mtime_lo %h not above previous %h",
						$time, got.data, last_mtime));
				end
				last_mtime = got.data;
				have_mtime = 1'b1;
			end else begin
				// Upper half stays zero over a run this short
				check_data(got.data, '0, "clint data");
			end
		end else begin
			check_data(got.data, expected_word(addr), "lsu data");
		end
	endtask

	task automatic issue_lsu_write(input addr_t addr, input data_t wdata, input strb_t strb,
		input resp_t exp_resp);
		b_t got;
		@(negedge clock);
		lsu_aw.addr = addr;
		lsu_aw.size = 3'd2;
		lsu_w.data  = wdata;
		lsu_w.strb  = strb;
		lsu_awvalid = 1'b1;
		lsu_wvalid  = 1'b1;
		lsu_bready  = 1'b1;
		@(posedge clock);
		while (!(lsu_awready && lsu_wready)) begin
			@(posedge clock);
		end
		check_last(io_wlast, 1'b1, "wlast on write beat");  // Every write is its own last beat
		@(negedge clock);
		lsu_awvalid = 1'b0;
		lsu_wvalid  = 1'b0;
		@(posedge clock);
		while (!lsu_bvalid) begin
			@(posedge clock);
		end
		got = lsu_b;
		check_resp(got.resp, exp_resp, "write resp");
		check_last(io_wlast, 1'b0, "wlast with no write beat");
		model_mem[{addr[31:2], 2'b00}] = merge_bytes(expected_word(addr), wdata, strb);
		@(negedge clock);
		lsu_bready = 1'b0;
	endtask

	task automatic run_line(input int idx);
		int         base;
		logic [3:0] op;
		addr_t      addr;
		len_t       len;
		data_t      wdata;
		strb_t      strb;
		resp_t      resp;
		base  = idx * words_per_line;
		op    = stim_words[base][3:0];
		addr  = stim_words[base + 1];
		len   = stim_words[base + 2][7:0];
		wdata = stim_words[base + 3];
		strb  = stim_words[base + 4][3:0];
		resp  = stim_words[base + 5][1:0];
		case (op)
			op_ifu_read:  issue_ifu_read(addr, len, resp);
			op_lsu_read:  issue_lsu_read(addr, resp);
			op_lsu_write: issue_lsu_write(addr, wdata, strb, resp);
			op_paired: begin
				fork
					issue_ifu_read(addr, len, resp);
					issue_lsu_read(wdata, resp);  // LSU address sits in the data column
				join
				if (lsu_first_time <= ifu_last_time) begin
					stop_on_error($sformatf("mismatch at %0t: LSU read finished before IFU burst",
						$time));
				end
			end
			default: begin
				stop_on_error($sformatf("stimulus line %0d has unknown operation code %h", idx, op));
			end
		endcase
	endtask

	initial begin : rready_stalls
		logic [31:0] rnd;
		seed       = 32'h4a81e919;
		ifu_rready = 1'b0;
		lsu_rready = 1'b0;
		forever begin
			@(negedge clock);
			if (arst_n === 1'b1) begin
				rnd        = $random(seed);
				ifu_rready = (rnd[1:0] != 2'b00);  // Low about one beat in four
				lsu_rready = (rnd[3:2] != 2'b00);
			end
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		forever begin
			@(posedge clock);
			cycle_count++;
			if (cycle_limit > 0 && cycle_count > cycle_limit) begin
				stop_on_error($sformatf("timeout: %0d stimulus lines did not finish in %0d cycles",
					num_lines, cycle_limit));
			end
		end
	end

	initial begin : main
		ifu_ar      = '0;
		ifu_arvalid = 1'b0;
		lsu_ar      = '0;
		lsu_arvalid = 1'b0;
		lsu_aw      = '0;
		lsu_awvalid = 1'b0;
		lsu_w       = '0;
		lsu_wvalid  = 1'b0;
		lsu_bready  = 1'b0;
		for (int i = 0; i < max_lines * words_per_line; i++) begin
			stim_words[i] = '0;
		end
		$readmemh("dv/xbar_stimulus.txt", stim_words);
		num_lines = 0;
		while (num_lines < max_lines && stim_words[num_lines * words_per_line] != '0) begin
			num_lines++;
		end
		if (num_lines == 0) begin
			stop_on_error("no stimulus lines were read from dv/xbar_stimulus.txt");
		end
		cycle_limit = cycles_per_line * num_lines + reset_margin;
		wait (arst_n === 1'b1);
		for (int i = 0; i < num_lines; i++) begin
			run_line(i);
		end
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* dv/xbar_stimulus.txt */
// Columns in hex: op addr len wdata strb resp
// op 1 IFU read, 2 LSU read, 3 LSU write, 4 IFU read paired with LSU read of the wdata column
1 00001000 03 00000000 0 0 // IFU burst of four words
1 00001010 00 00000000 0 0
1 00001800 07 00000000 0 0
3 00002000 00 cafef00d f 0 // Write then read back
2 00002000 00 00000000 0 0
3 00002004 00 12345678 3 0 // Low half only
2 00002004 00 00000000 0 0
3 00002004 00 9abcdef0 c 0 // Then the high half
2 00002004 00 00000000 0 0
2 00002008 00 00000000 0 0 // Untouched word keeps the pattern
2 020000f8 00 00000000 0 0 // mtime_lo twice, must advance
2 020000f8 00 00000000 0 0
2 020000fc 00 00000000 0 0
2 02000010 00 00000000 0 3 // Unmapped timer offsets
2 0200fffc 00 00000000 0 3
2 02010000 00 00000000 0 0 // Just past the CLINT window
4 00003000 03 00003100 0 0 // Paired reads
4 00001000 01 00002000 0 0
4 00004000 07 020000f8 0 0 // LSU side reads the timer
3 00003104 00 0badc0de f 0
4 00003100 02 00003104 0 0
1 00003100 02 00000000 0 0
2 020000f8 00 00000000 0 0
4 00005000 05 00005014 0 0
3 00005014 00 a5a5a5a5 1 0
4 00005010 01 00005014 0 0
2 00001ffc 00 00000000 0 0
1 0000fff0 03 00000000 0 0

/* files.f */
src/axi_pkg.sv
src/soc_map_pkg.sv
src/read_arbiter.sv
src/xbar.sv
src/clint.sv
src/core_bus_top.sv
dv/tb_clock_gen.sv
dv/soc_mem_responder.sv
dv/tb_core_bus.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core bus testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_core_bus -f files.f \
	> sim.log 2>&1 \
	&& ./obj_dir/Vtb_core_bus >> sim.log 2>&1 \
	|| echo "CHECKS FAILED" >> sim.log

cat sim.log
! grep -q "CHECKS FAILED" sim.log

/* src/axi_pkg.sv */
package axi_pkg;

	// Field widths of the core bus
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;
	typedef logic [7:0]  len_t;   // Beats minus one
	typedef logic [2:0]  size_t;  // log2 of bytes per beat
	typedef logic [1:0]  burst_t;

	localparam resp_t resp_okay   = 2'd0;
	localparam resp_t resp_decerr = 2'd3;

	typedef struct packed {
		addr_t  addr;
		len_t   len;
		size_t  size;
		burst_t burst;
	} ar_t;

	typedef struct packed {
		data_t data;
		resp_t resp;
		logic  last;
	} r_t;

	// Writes are single beat, no len or burst needed
	typedef struct packed {
		addr_t addr;
		size_t size;
	} aw_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_t;

	typedef struct packed {
		resp_t resp;
	} b_t;

endpackage

/* src/clint.sv */
`timescale 1ns/100ps

module clint #(
	parameter int tick_div = 2
) (
	input  logic         clock,
	input  logic         arst_n,
	input  axi_pkg::ar_t ar,
	input  logic         arvalid,
	output logic         arready,
	output axi_pkg::r_t  r,
	output logic         rvalid,
	input  logic         rready
);
	import axi_pkg::*;
	import soc_map_pkg::*;

	localparam int div_w = (tick_div > 1) ? $clog2(tick_div) : 1;

	typedef logic [63:0] mtime_t;

	mtime_t           mtime;
	logic [div_w-1:0] div_cnt;
	logic             tick;
	addr_t            offset;
	logic             ar_fire;

	assign tick = (div_cnt == div_w'(tick_div - 1));

	// Prescaler and free-running timer
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
			mtime   <= '0;
		end else if (tick) begin
			div_cnt <= '0;
			mtime   <= mtime + 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign offset  = ar.addr - clint_base;
	assign arready = !rvalid;  // One read at a time
	assign ar_fire = arvalid && arready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
		end else if (ar_fire) begin
			rvalid <= 1'b1;
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
		end
	end

	// Timer sampled at the address handshake
	always_ff @(posedge clock) begin
		if (ar_fire) begin
			r.last <= 1'b1;
			case (offset)
				addr_t'(mtime_lo_off): begin
					r.data <= mtime[31:0];
					r.resp <= resp_okay;
				end
				addr_t'(mtime_hi_off): begin
					r.data <= mtime[63:32];
					r.resp <= resp_okay;
				end
				default: begin
					r.data <= '0;
					r.resp <= resp_decerr;
				end
			endcase
		end
	end

endmodule

/* src/core_bus_top.sv */
`timescale 1ns/100ps

module core_bus_top #(
	parameter int beat_cnt_w = 4,
	parameter int tick_div   = 2
) (
	input  logic         clock,
	input  logic         arst_n,

	input  axi_pkg::ar_t ifu_ar,
	input  logic         ifu_arvalid,
	output logic         ifu_arready,
	output axi_pkg::r_t  ifu_r,
	output logic         ifu_rvalid,
	input  logic         ifu_rready,

	input  axi_pkg::ar_t lsu_ar,
	input  logic         lsu_arvalid,
	output logic         lsu_arready,
	output axi_pkg::r_t  lsu_r,
	output logic         lsu_rvalid,
	input  logic         lsu_rready,
	input  axi_pkg::aw_t lsu_aw,
	input  logic         lsu_awvalid,
	output logic         lsu_awready,
	input  axi_pkg::w_t  lsu_w,
	input  logic         lsu_wvalid,
	output logic         lsu_wready,
	output axi_pkg::b_t  lsu_b,
	output logic         lsu_bvalid,
	input  logic         lsu_bready,

	output axi_pkg::ar_t io_ar,
	output logic         io_arvalid,
	input  logic         io_arready,
	input  axi_pkg::r_t  io_r,
	input  logic         io_rvalid,
	output logic         io_rready,
	output axi_pkg::aw_t io_aw,
	output logic         io_awvalid,
	input  logic         io_awready,
	output axi_pkg::w_t  io_w,
	output logic         io_wvalid,
	output logic         io_wlast,
	input  logic         io_wready,
	input  axi_pkg::b_t  io_b,
	input  logic         io_bvalid,
	output logic         io_bready
);
	import axi_pkg::*;

	// Switch to timer
	ar_t  clint_ar;
	logic clint_arvalid;
	logic clint_arready;
	r_t   clint_r;
	logic clint_rvalid;
	logic clint_rready;

	xbar #(
		.beat_cnt_w(beat_cnt_w)
	) xbar0 (
		.clock        (clock),
		.arst_n       (arst_n),
		.ifu_ar       (ifu_ar),
		.ifu_arvalid  (ifu_arvalid),
		.ifu_arready  (ifu_arready),
		.ifu_r        (ifu_r),
		.ifu_rvalid   (ifu_rvalid),
		.ifu_rready   (ifu_rready),
		.lsu_ar       (lsu_ar),
		.lsu_arvalid  (lsu_arvalid),
		.lsu_arready  (lsu_arready),
		.lsu_r        (lsu_r),
		.lsu_rvalid   (lsu_rvalid),
		.lsu_rready   (lsu_rready),
		.lsu_aw       (lsu_aw),
		.lsu_awvalid  (lsu_awvalid),
		.lsu_awready  (lsu_awready),
		.lsu_w        (lsu_w),
		.lsu_wvalid   (lsu_wvalid),
		.lsu_wready   (lsu_wready),
		.lsu_b        (lsu_b),
		.lsu_bvalid   (lsu_bvalid),
		.lsu_bready   (lsu_bready),
		.io_ar        (io_ar),
		.io_arvalid   (io_arvalid),
		.io_arready   (io_arready),
		.io_r         (io_r),
		.io_rvalid    (io_rvalid),
		.io_rready    (io_rready),
		.io_aw        (io_aw),
		.io_awvalid   (io_awvalid),
		.io_awready   (io_awready),
		.io_w         (io_w),
		.io_wvalid    (io_wvalid),
		.io_wlast     (io_wlast),
		.io_wready    (io_wready),
		.io_b         (io_b),
		.io_bvalid    (io_bvalid),
		.io_bready    (io_bready),
		.clint_ar     (clint_ar),
		.clint_arvalid(clint_arvalid),
		.clint_arready(clint_arready),
		.clint_r      (clint_r),
		.clint_rvalid (clint_rvalid),
		.clint_rready (clint_rready)
	);

	clint #(
		.tick_div(tick_div)
	) clint0 (
		.clock  (clock),
		.arst_n (arst_n),
		.ar     (clint_ar),
		.arvalid(clint_arvalid),
		.arready(clint_arready),
		.r      (clint_r),
		.rvalid (clint_rvalid),
		.rready (clint_rready)
	);

endmodule

/* src/read_arbiter.sv */
`timescale 1ns/100ps

module read_arbiter #(
	parameter int beat_cnt_w = 4
) (
	input  logic                clock,
	input  logic                arst_n,
	input  logic                ifu_req,
	input  logic                lsu_req,
	input  logic                ar_fire,
	input  axi_pkg::len_t       ar_len,
	input  logic                r_fire,
	input  logic                r_done,
	output soc_map_pkg::grant_e grant,
	output logic                last_beat
);
	import soc_map_pkg::*;

	logic [beat_cnt_w-1:0] beat_cnt;
	grant_e                grant_next;

	assign last_beat = (beat_cnt == '0);

	always_comb begin
		grant_next = grant;
		case (grant)
			GRANT_NONE: begin
				if (ifu_req) begin  // Fetch wins a tie
					grant_next = GRANT_IFU;
				end else if (lsu_req) begin
					grant_next = GRANT_LSU;
				end
			end
			GRANT_IFU,
			GRANT_LSU: begin
				if (r_done && last_beat) begin
					grant_next = GRANT_NONE;
				end
			end
			default: begin
				grant_next = GRANT_NONE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			grant <= GRANT_NONE;
		end else begin
			grant <= grant_next;
		end
	end

	// Loaded with the burst length, counted down per SoC beat
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			beat_cnt <= '0;
		end else if (ar_fire) begin
			beat_cnt <= ar_len[beat_cnt_w-1:0];
		end else if (r_fire && !last_beat) begin
			beat_cnt <= beat_cnt - 1'b1;
		end
	end

	// A beat at count zero has to close the burst, never borrow below zero
	a_no_underflow: assert property (@(posedge clock) disable iff (!arst_n)
		r_fire && last_beat |=> grant == GRANT_NONE);

	a_grant_held: assert property (@(posedge clock) disable iff (!arst_n)
		beat_cnt != '0 |=> $stable(grant));

endmodule

/* src/soc_map_pkg.sv */
package soc_map_pkg;

	// CLINT window on the core bus
	localparam axi_pkg::addr_t clint_base  = 32'h0200_0000;
	localparam axi_pkg::addr_t clint_limit = 32'h0200_ffff;

	// Timer register offsets inside the window
	localparam logic [7:0] mtime_lo_off = 8'hf8;
	localparam logic [7:0] mtime_hi_off = 8'hfc;

	// Owner of the shared read path
	typedef enum logic [1:0] {
		GRANT_NONE,
		GRANT_IFU,
		GRANT_LSU
	} grant_e;

endpackage

/* src/xbar.sv */
`timescale 1ns/100ps

module xbar #(
	parameter int beat_cnt_w = 4
) (
	input  logic         clock,
	input  logic         arst_n,

	input  axi_pkg::ar_t ifu_ar,
	input  logic         ifu_arvalid,
	output logic         ifu_arready,
	output axi_pkg::r_t  ifu_r,
	output logic         ifu_rvalid,
	input  logic         ifu_rready,

	input  axi_pkg::ar_t lsu_ar,
	input  logic         lsu_arvalid,
	output logic         lsu_arready,
	output axi_pkg::r_t  lsu_r,
	output logic         lsu_rvalid,
	input  logic         lsu_rready,
	input  axi_pkg::aw_t lsu_aw,
	input  logic         lsu_awvalid,
	output logic         lsu_awready,
	input  axi_pkg::w_t  lsu_w,
	input  logic         lsu_wvalid,
	output logic         lsu_wready,
	output axi_pkg::b_t  lsu_b,
	output logic         lsu_bvalid,
	input  logic         lsu_bready,

	output axi_pkg::ar_t io_ar,
	output logic         io_arvalid,
	input  logic         io_arready,
	input  axi_pkg::r_t  io_r,
	input  logic         io_rvalid,
	output logic         io_rready,
	output axi_pkg::aw_t io_aw,
	output logic         io_awvalid,
	input  logic         io_awready,
	output axi_pkg::w_t  io_w,
	output logic         io_wvalid,
	output logic         io_wlast,
	input  logic         io_wready,
	input  axi_pkg::b_t  io_b,
	input  logic         io_bvalid,
	output logic         io_bready,

	output axi_pkg::ar_t clint_ar,
	output logic         clint_arvalid,
	input  logic         clint_arready,
	input  axi_pkg::r_t  clint_r,
	input  logic         clint_rvalid,
	output logic         clint_rready
);
	import axi_pkg::*;
	import soc_map_pkg::*;

	grant_e grant;
	logic   ifu_granted;
	logic   lsu_granted;
	logic   lsu_clint_hit;  // Live decode of the LSU address
	logic   clint_sel;      // Route held for the LSU response
	logic   ar_fire;
	logic   r_fire;
	logic   r_done;

	assign ifu_granted   = (grant == GRANT_IFU);
	assign lsu_granted   = (grant == GRANT_LSU);
	assign lsu_clint_hit = (lsu_ar.addr >= clint_base) && (lsu_ar.addr <= clint_limit);

	assign io_arvalid    = ifu_granted && ifu_arvalid
		|| lsu_granted && !lsu_clint_hit && lsu_arvalid;
	assign clint_arvalid = lsu_granted && lsu_clint_hit && lsu_arvalid;
	assign ifu_arready   = ifu_granted && io_arready;
	assign lsu_arready   = lsu_granted && (lsu_clint_hit ? clint_arready : io_arready);

	always_comb begin
		if (ifu_granted) begin
			io_ar      = ifu_ar;
			io_ar.size = size_t'(2);  // Fetch is always a full word
		end else begin
			io_ar     = lsu_ar;
			io_ar.len = '0;
		end
	end
	assign clint_ar = lsu_ar;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			clint_sel <= 1'b0;
		end else if (lsu_arvalid && lsu_arready) begin
			clint_sel <= lsu_clint_hit;
		end
	end

	assign ifu_r        = io_r;
	assign lsu_r        = clint_sel ? clint_r : io_r;
	assign ifu_rvalid   = ifu_granted && io_rvalid;
	assign lsu_rvalid   = lsu_granted && (clint_sel ? clint_rvalid : io_rvalid);
	assign io_rready    = ifu_granted && ifu_rready || lsu_granted && !clint_sel && lsu_rready;
	assign clint_rready = lsu_granted && clint_sel && lsu_rready;

	assign ar_fire = ifu_arvalid && ifu_arready || lsu_arvalid && lsu_arready;
	assign r_fire  = io_rvalid && io_rready;
	assign r_done  = ifu_rvalid && ifu_rready || lsu_rvalid && lsu_rready;

	read_arbiter #(
		.beat_cnt_w(beat_cnt_w)
	) arb0 (
		.clock    (clock),
		.arst_n   (arst_n),
		.ifu_req  (ifu_arvalid),
		.lsu_req  (lsu_arvalid),
		.ar_fire  (ar_fire),
		.ar_len   (io_ar.len),
		.r_fire   (r_fire),
		.r_done   (r_done),
		.grant    (grant),
		.last_beat()
	);

	// Writes go straight to the SoC
	assign io_aw       = lsu_aw;
	assign io_awvalid  = lsu_awvalid;
	assign lsu_awready = io_awready;
	assign io_w        = lsu_w;
	assign io_wvalid   = lsu_wvalid;
	assign io_wlast    = lsu_wvalid;  // Single beat
	assign lsu_wready  = io_wready;
	assign lsu_b       = io_b;
	assign lsu_bvalid  = io_bvalid;
	assign io_bready   = lsu_bready;

	a_one_target: assert property (@(posedge clock) disable iff (!arst_n)
		!(io_arvalid && clint_arvalid));

endmodule
